/* all.f */
+incdir+rtl
rtl/mcu_pkg.sv
rtl/sram_bank.sv
rtl/slow_memory.sv
rtl/periph_regs.sv
rtl/obi_bus.sv
rtl/mini_mcu.sv
test/tb_mini_mcu.sv

/* Makefile */
# Verilator build and run for the mini_mcu testbench
# pass or fail is taken from the simulation log

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_mini_mcu
RTL_TOP   ?= mini_mcu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_mini_mcu.sv */
// directed testbench for mini_mcu, drives both OBI masters as CPU stand-ins
// a memory model in the testbench tracks every word written over the data port

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int RAM_WORDS_TESTED  = 8;
  localparam int SLOW_WORDS_TESTED = 6;
  // four transfers per RAM word, three per slow word, a few more elsewhere
  localparam int NUM_TXN     = 4 * RAM_WORDS_TESTED + 3 * SLOW_WORDS_TESTED + 20;
  localparam int CYCLE_LIMIT = NUM_TXN * (`MCU_SLOW_MAX_LAT + 2) + 50;

  logic        clk_i;
  logic        rst_i;
  logic        instr_req_i;
  addr_t       instr_addr_i;
  logic        instr_gnt_o;
  logic        instr_rvalid_o;
  data_t       instr_rdata_o;
  logic        data_req_i;
  logic        data_we_i;
  be_t         data_be_i;
  addr_t       data_addr_i;
  data_t       data_wdata_i;
  logic        data_gnt_o;
  logic        data_rvalid_o;
  data_t       data_rdata_o;
  logic        exit_valid_o;
  data_t       exit_value_o;
  logic [31:0] lfsr_q = 32'h3ae5_c0e1;
  int          value_errs = 0;
  int          other_errs = 0;
  int          cycle_cnt = 0;
  data_t       model [addr_t];
  addr_t       ram_probe;

  mini_mcu dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], lfsr_bit()};
    return r;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("Fail %0t %s: got %h, expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Fail %0t %s: got %0d, expected %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_between(input string what, input int got, input int lo, input int hi);
    assert (got >= lo && got <= hi) else begin
      $display("Fail %0t %s: got %0d, expected %0d to %0d", $time, what, got, lo, hi);
      value_errs++;
    end
  endtask

  // called on a rising edge; waits counts gnt-low cycles, lat counts gnt to rvalid
  task automatic obi_write(input addr_t addr, input data_t wdata, input be_t be,
                           output int waits, output int lat);
    waits = 0;
    lat = 0;
    data_req_i   <= 1'b1;
    data_we_i    <= 1'b1;
    data_be_i    <= be;
    data_addr_i  <= addr;
    data_wdata_i <= wdata;
    @(posedge clk_i);
    while (!data_gnt_o) begin
      waits++;
      @(posedge clk_i);
    end
    data_req_i <= 1'b0;
    data_we_i  <= 1'b0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!data_rvalid_o);
  endtask

  task automatic obi_read(input addr_t addr, output data_t rdata, output int waits,
                          output int lat);
    waits = 0;
    lat = 0;
    data_req_i  <= 1'b1;
    data_we_i   <= 1'b0;
    data_be_i   <= 4'hf;
    data_addr_i <= addr;
    @(posedge clk_i);
    while (!data_gnt_o) begin
      waits++;
      @(posedge clk_i);
    end
    data_req_i <= 1'b0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!data_rvalid_o);
    rdata = data_rdata_o;
  endtask

  task automatic fetch_read(input addr_t addr, output data_t rdata, output int waits,
                            output int lat);
    waits = 0;
    lat = 0;
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    @(posedge clk_i);
    while (!instr_gnt_o) begin
      waits++;
      @(posedge clk_i);
    end
    instr_req_i <= 1'b0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!instr_rvalid_o);
    rdata = instr_rdata_o;
  endtask

  // write through the data port and keep the model in step
  task automatic store_word(input addr_t addr, input data_t wdata, input be_t be,
                            output int lat);
    int waits;
    obi_write(addr, wdata, be, waits, lat);
    model[addr] = model.exists(addr) ? merge_bytes(model[addr], wdata, be) : wdata;
  endtask

  task automatic test_ram_access();
    addr_t addr;
    data_t rdata;
    int    waits;
    int    lat;
    for (int i = 0; i < RAM_WORDS_TESTED; i++) begin
      addr = ((i % 2 == 0) ? `MCU_RAM0_BASE : `MCU_RAM1_BASE) + (rand_bits(12) << 2);
      store_word(addr, rand_bits(32), 4'hf, lat);
      check_count("data_rvalid_o write latency", lat, 1);
      store_word(addr, rand_bits(32), be_t'(rand_bits(4)), lat);
      obi_read(addr, rdata, waits, lat);
      check_value("data_rdata_o", rdata, model[addr]);
      check_count("data_gnt_o wait cycles", waits, 0);
      check_count("data_rvalid_o latency", lat, 1);
      fetch_read(addr, rdata, waits, lat);
      check_value("instr_rdata_o", rdata, model[addr]);
      check_count("instr_rvalid_o latency", lat, 1);
      ram_probe = addr;
    end
  endtask

  task automatic test_slow_memory();
    addr_t addr;
    addr_t first;
    data_t rdata;
    data_t fetched;
    int    waits;
    int    fetch_waits;
    int    lat;
    int    fetch_lat;
    first = `MCU_SLOW_BASE;
    for (int i = 0; i < SLOW_WORDS_TESTED; i++) begin
      addr = `MCU_SLOW_BASE + (rand_bits(7) << 2);
      if (i == 0)
        first = addr;
      store_word(addr, rand_bits(32), 4'hf, lat);
      check_between("slow write latency", lat, 1, `MCU_SLOW_MAX_LAT);
      store_word(addr, rand_bits(32), be_t'(rand_bits(4)), lat);
      check_between("slow write latency", lat, 1, `MCU_SLOW_MAX_LAT);
      obi_read(addr, rdata, waits, lat);
      check_value("data_rdata_o (slow)", rdata, model[addr]);
      check_between("slow read latency", lat, 1, `MCU_SLOW_MAX_LAT);
    end
    // fetch occupies the slow RAM, the data read must hold req until granted
    fork
      fetch_read(first, fetched, fetch_waits, fetch_lat);
      begin
        @(posedge clk_i);
        obi_read(addr, rdata, waits, lat);
      end
    join
    check_value("instr_rdata_o (slow)", fetched, model[first]);
    check_value("data_rdata_o (slow, held)", rdata, model[addr]);
    assert (waits >= 1) else begin
      $display("data master was granted while the slow memory was still busy");
      other_errs++;
    end
  endtask

  task automatic test_arbitration();
    addr_t a0;
    addr_t a1;
    addr_t b0;
    data_t rd_d;
    data_t rd_i;
    int    waits_d;
    int    waits_i;
    int    lat_d;
    int    lat_i;
    a0 = `MCU_RAM0_BASE + 32'h100;
    a1 = `MCU_RAM0_BASE + 32'h104;
    b0 = `MCU_RAM1_BASE + 32'h100;
    store_word(a0, rand_bits(32), 4'hf, lat_d);
    store_word(a1, rand_bits(32), 4'hf, lat_d);
    store_word(b0, rand_bits(32), 4'hf, lat_d);
    fork
      obi_read(a0, rd_d, waits_d, lat_d);
      fetch_read(a1, rd_i, waits_i, lat_i);
    join
    check_value("data_rdata_o (same bank)", rd_d, model[a0]);
    check_value("instr_rdata_o (same bank)", rd_i, model[a1]);
    check_count("data_gnt_o wait cycles (same bank)", waits_d, 0);
    check_count("instr_gnt_o wait cycles (same bank)", waits_i, 1);
    fork
      obi_read(a0, rd_d, waits_d, lat_d);
      fetch_read(b0, rd_i, waits_i, lat_i);
    join
    check_value("data_rdata_o (two banks)", rd_d, model[a0]);
    check_value("instr_rdata_o (two banks)", rd_i, model[b0]);
    check_count("data_gnt_o wait cycles (two banks)", waits_d, 0);
    check_count("instr_gnt_o wait cycles (two banks)", waits_i, 0);
  endtask

  task automatic test_exit_register();
    data_t word;
    data_t rdata;
    int    waits;
    int    lat;
    check_value("exit_valid_o", 32'(exit_valid_o), 32'd0);
    word = rand_bits(32);
    obi_write(`MCU_PERIPH_BASE + 32'(`MCU_PERIPH_EXIT), word, 4'hf, waits, lat);
    check_count("periph write latency", lat, 1);
    check_value("exit_valid_o", 32'(exit_valid_o), 32'd1);
    check_value("exit_value_o", exit_value_o, word);
    word = rand_bits(32);
    obi_write(`MCU_PERIPH_BASE + 32'(`MCU_PERIPH_SCRATCH), word, 4'hf, waits, lat);
    obi_read(`MCU_PERIPH_BASE + 32'(`MCU_PERIPH_SCRATCH), rdata, waits, lat);
    check_value("data_rdata_o (scratch)", rdata, word);
    check_count("periph read latency", lat, 1);
  endtask

  task automatic test_unmapped_and_timer();
    data_t rdata;
    data_t t_first;
    data_t t_second;
    int    waits;
    int    lat;
    obi_read(32'h1000_0000, rdata, waits, lat);
    check_value("data_rdata_o (unmapped)", rdata, `MCU_UNMAPPED_RDATA);
    check_count("unmapped read latency", lat, 1);
    fetch_read(`MCU_RAM1_BASE + `MCU_RAM_BYTES, rdata, waits, lat);
    check_value("instr_rdata_o (unmapped)", rdata, `MCU_UNMAPPED_RDATA);
    // same low bits as a RAM word, must not reach the bank
    obi_write(32'h1000_0000 | ram_probe, rand_bits(32), 4'hf, waits, lat);
    obi_read(ram_probe, rdata, waits, lat);
    check_value("data_rdata_o (after unmapped write)", rdata, model[ram_probe]);
    obi_read(`MCU_PERIPH_BASE + 32'(`MCU_PERIPH_TIMER), t_first, waits, lat);
    obi_read(`MCU_PERIPH_BASE + 32'(`MCU_PERIPH_TIMER), t_second, waits, lat);
    assert (t_second > t_first) else begin
      $display("Fail %0t timer: got %h, expected more than %h", $time, t_second, t_first);
      value_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: a transfer did not complete within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    rst_i        = 1'b1;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    test_exit_register();
    test_ram_access();
    test_slow_memory();
    test_arbitration();
    test_unmapped_and_timer();
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mini_mcu.sv */
// top level of the fabric; CPU fetch and data ports come in as OBI masters
// bus feeds two RAM banks, the peripheral registers and the slow RAM

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module mini_mcu (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           instr_req_i,
  input  mcu_pkg::addr_t instr_addr_i,
  output logic           instr_gnt_o,
  output logic           instr_rvalid_o,
  output mcu_pkg::data_t instr_rdata_o,
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  mcu_pkg::be_t   data_be_i,
  input  mcu_pkg::addr_t data_addr_i,
  input  mcu_pkg::data_t data_wdata_i,
  output logic           data_gnt_o,
  output logic           data_rvalid_o,
  output mcu_pkg::data_t data_rdata_o,
  output logic           exit_valid_o,
  output mcu_pkg::data_t exit_value_o
);

  import mcu_pkg::*;

  localparam int RAM_WORDS = `MCU_RAM_BYTES / 4;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int SLOW_AW   = $clog2(`MCU_SLOW_WORDS);

  logic  ram0_req, ram0_we, ram0_gnt, ram0_rvalid;
  be_t   ram0_be;
  addr_t ram0_addr;
  data_t ram0_wdata, ram0_rdata;
  logic  ram1_req, ram1_we, ram1_gnt, ram1_rvalid;
  be_t   ram1_be;
  addr_t ram1_addr;
  data_t ram1_wdata, ram1_rdata;
  logic  periph_req, periph_we, periph_gnt, periph_rvalid;
  be_t   periph_be;
  addr_t periph_addr;
  data_t periph_wdata, periph_rdata;
  logic  slow_req, slow_we, slow_gnt, slow_rvalid;
  be_t   slow_be;
  addr_t slow_addr;
  data_t slow_wdata, slow_rdata;

  obi_bus bus0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .ram0_req_o     (ram0_req),
    .ram0_we_o      (ram0_we),
    .ram0_be_o      (ram0_be),
    .ram0_addr_o    (ram0_addr),
    .ram0_wdata_o   (ram0_wdata),
    .ram0_gnt_i     (ram0_gnt),
    .ram0_rvalid_i  (ram0_rvalid),
    .ram0_rdata_i   (ram0_rdata),
    .ram1_req_o     (ram1_req),
    .ram1_we_o      (ram1_we),
    .ram1_be_o      (ram1_be),
    .ram1_addr_o    (ram1_addr),
    .ram1_wdata_o   (ram1_wdata),
    .ram1_gnt_i     (ram1_gnt),
    .ram1_rvalid_i  (ram1_rvalid),
    .ram1_rdata_i   (ram1_rdata),
    .periph_req_o   (periph_req),
    .periph_we_o    (periph_we),
    .periph_be_o    (periph_be),
    .periph_addr_o  (periph_addr),
    .periph_wdata_o (periph_wdata),
    .periph_gnt_i   (periph_gnt),
    .periph_rvalid_i(periph_rvalid),
    .periph_rdata_i (periph_rdata),
    .slow_req_o     (slow_req),
    .slow_we_o      (slow_we),
    .slow_be_o      (slow_be),
    .slow_addr_o    (slow_addr),
    .slow_wdata_o   (slow_wdata),
    .slow_gnt_i     (slow_gnt),
    .slow_rvalid_i  (slow_rvalid),
    .slow_rdata_i   (slow_rdata)
  );

  // banks are aligned to their size, so the low bits give the word index
  sram_bank #(
    .NUM_WORDS(RAM_WORDS)
  ) ram0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (ram0_req),
    .we_i    (ram0_we),
    .be_i    (ram0_be),
    .addr_i  (ram0_addr[RAM_AW+1:2]),
    .wdata_i (ram0_wdata),
    .gnt_o   (ram0_gnt),
    .rvalid_o(ram0_rvalid),
    .rdata_o (ram0_rdata)
  );

  sram_bank #(
    .NUM_WORDS(RAM_WORDS)
  ) ram1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (ram1_req),
    .we_i    (ram1_we),
    .be_i    (ram1_be),
    .addr_i  (ram1_addr[RAM_AW+1:2]),
    .wdata_i (ram1_wdata),
    .gnt_o   (ram1_gnt),
    .rvalid_o(ram1_rvalid),
    .rdata_o (ram1_rdata)
  );

  periph_regs periph0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (periph_req),
    .we_i        (periph_we),
    .be_i        (periph_be),
    .addr_i      (periph_addr[11:0]),
    .wdata_i     (periph_wdata),
    .gnt_o       (periph_gnt),
    .rvalid_o    (periph_rvalid),
    .rdata_o     (periph_rdata),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

  slow_memory #(
    .NUM_WORDS(`MCU_SLOW_WORDS)
  ) slow0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (slow_req),
    .we_i    (slow_we),
    .be_i    (slow_be),
    .addr_i  (slow_addr[SLOW_AW+1:2]),
    .wdata_i (slow_wdata),
    .gnt_o   (slow_gnt),
    .rvalid_o(slow_rvalid),
    .rdata_o (slow_rdata)
  );

endmodule

`default_nettype wire

/* rtl/obi_bus.sv */
// OBI interconnect for two masters and four slaves
// data master wins a shared slave, unmapped accesses get an error word

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module obi_bus (
  input  logic           clk_i,
  input  logic           rst_i,
  // instruction master, reads only
  input  logic           instr_req_i,
  input  mcu_pkg::addr_t instr_addr_i,
  output logic           instr_gnt_o,
  output logic           instr_rvalid_o,
  output mcu_pkg::data_t instr_rdata_o,
  // data master
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  mcu_pkg::be_t   data_be_i,
  input  mcu_pkg::addr_t data_addr_i,
  input  mcu_pkg::data_t data_wdata_i,
  output logic           data_gnt_o,
  output logic           data_rvalid_o,
  output mcu_pkg::data_t data_rdata_o,
  // slaves
  output logic           ram0_req_o,
  output logic           ram0_we_o,
  output mcu_pkg::be_t   ram0_be_o,
  output mcu_pkg::addr_t ram0_addr_o,
  output mcu_pkg::data_t ram0_wdata_o,
  input  logic           ram0_gnt_i,
  input  logic           ram0_rvalid_i,
  input  mcu_pkg::data_t ram0_rdata_i,
  output logic           ram1_req_o,
  output logic           ram1_we_o,
  output mcu_pkg::be_t   ram1_be_o,
  output mcu_pkg::addr_t ram1_addr_o,
  output mcu_pkg::data_t ram1_wdata_o,
  input  logic           ram1_gnt_i,
  input  logic           ram1_rvalid_i,
  input  mcu_pkg::data_t ram1_rdata_i,
  output logic           periph_req_o,
  output logic           periph_we_o,
  output mcu_pkg::be_t   periph_be_o,
  output mcu_pkg::addr_t periph_addr_o,
  output mcu_pkg::data_t periph_wdata_o,
  input  logic           periph_gnt_i,
  input  logic           periph_rvalid_i,
  input  mcu_pkg::data_t periph_rdata_i,
  output logic           slow_req_o,
  output logic           slow_we_o,
  output mcu_pkg::be_t   slow_be_o,
  output mcu_pkg::addr_t slow_addr_o,
  output mcu_pkg::data_t slow_wdata_o,
  input  logic           slow_gnt_i,
  input  logic           slow_rvalid_i,
  input  mcu_pkg::data_t slow_rdata_i
);

  import mcu_pkg::*;

  localparam int    NUM_SLAVES   = 4;
  localparam addr_t PERIPH_BYTES = 32'h0000_1000;

  slave_sel_e            instr_sel;
  slave_sel_e            data_sel;
  logic                  instr_out_q;
  logic                  data_out_q;
  logic                  instr_unm_q;
  logic                  data_unm_q;
  logic                  instr_free;
  logic                  data_free;
  logic                  instr_unm;
  logic                  data_unm;
  logic [NUM_SLAVES-1:0] instr_want;
  logic [NUM_SLAVES-1:0] data_want;
  logic [NUM_SLAVES-1:0] s_req;
  logic [NUM_SLAVES-1:0] s_gnt;
  logic [NUM_SLAVES-1:0] s_rvalid;
  logic [NUM_SLAVES-1:0] pend_q;
  // owner per slave, 1 means the data master
  logic [NUM_SLAVES-1:0] owner_q;
  data_t                 s_rdata [NUM_SLAVES];

  function automatic slave_sel_e decode(input addr_t addr);
    if (addr >= `MCU_RAM0_BASE && addr < `MCU_RAM0_BASE + `MCU_RAM_BYTES)
      return SEL_RAM0;
    if (addr >= `MCU_RAM1_BASE && addr < `MCU_RAM1_BASE + `MCU_RAM_BYTES)
      return SEL_RAM1;
    if (addr >= `MCU_PERIPH_BASE && addr < `MCU_PERIPH_BASE + PERIPH_BYTES)
      return SEL_PERIPH;
    if (addr >= `MCU_SLOW_BASE && addr < `MCU_SLOW_BASE + `MCU_SLOW_WORDS * 4)
      return SEL_SLOW;
    return SEL_NONE;
  endfunction

  assign instr_sel = decode(instr_addr_i);
  assign data_sel  = decode(data_addr_i);

  assign s_gnt    = {slow_gnt_i, periph_gnt_i, ram1_gnt_i, ram0_gnt_i};
  assign s_rvalid = {slow_rvalid_i, periph_rvalid_i, ram1_rvalid_i, ram0_rvalid_i};
  assign s_rdata[0] = ram0_rdata_i;
  assign s_rdata[1] = ram1_rdata_i;
  assign s_rdata[2] = periph_rdata_i;
  assign s_rdata[3] = slow_rdata_i;

  // responses go back to whoever owns the slave
  assign instr_rvalid_o = |(s_rvalid & ~owner_q) | instr_unm_q;
  assign data_rvalid_o  = |(s_rvalid & owner_q) | data_unm_q;

  always_comb begin
    instr_rdata_o = `MCU_UNMAPPED_RDATA;
    data_rdata_o  = `MCU_UNMAPPED_RDATA;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (s_rvalid[i] && !owner_q[i])
        instr_rdata_o = s_rdata[i];
      if (s_rvalid[i] && owner_q[i])
        data_rdata_o = s_rdata[i];
    end
  end

  // one open transaction per master, a new one may go out as rvalid returns
  assign instr_free = !instr_out_q || instr_rvalid_o;
  assign data_free  = !data_out_q || data_rvalid_o;

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      instr_want[i] = instr_req_i && instr_free && (instr_sel == slave_sel_e'(i));
      data_want[i]  = data_req_i && data_free && (data_sel == slave_sel_e'(i));
    end
  end

  assign instr_unm = instr_req_i && instr_free && (instr_sel == SEL_NONE);
  assign data_unm  = data_req_i && data_free && (data_sel == SEL_NONE);

  // slave takes a request only with nothing pending or its response leaving
  assign s_req = (data_want | instr_want) & (~pend_q | s_rvalid);

  // data_want also selects the data master as the winner
  assign instr_gnt_o = |(s_req & s_gnt & ~data_want) | instr_unm;
  assign data_gnt_o  = |(s_req & s_gnt & data_want) | data_unm;

  assign ram0_req_o     = s_req[0];
  assign ram0_we_o      = data_want[0] & data_we_i;
  assign ram0_be_o      = data_want[0] ? data_be_i : '1;
  assign ram0_addr_o    = data_want[0] ? data_addr_i : instr_addr_i;
  assign ram0_wdata_o   = data_want[0] ? data_wdata_i : '0;
  assign ram1_req_o     = s_req[1];
  assign ram1_we_o      = data_want[1] & data_we_i;
  assign ram1_be_o      = data_want[1] ? data_be_i : '1;
  assign ram1_addr_o    = data_want[1] ? data_addr_i : instr_addr_i;
  assign ram1_wdata_o   = data_want[1] ? data_wdata_i : '0;
  assign periph_req_o   = s_req[2];
  assign periph_we_o    = data_want[2] & data_we_i;
  assign periph_be_o    = data_want[2] ? data_be_i : '1;
  assign periph_addr_o  = data_want[2] ? data_addr_i : instr_addr_i;
  assign periph_wdata_o = data_want[2] ? data_wdata_i : '0;
  assign slow_req_o     = s_req[3];
  assign slow_we_o      = data_want[3] & data_we_i;
  assign slow_be_o      = data_want[3] ? data_be_i : '1;
  assign slow_addr_o    = data_want[3] ? data_addr_i : instr_addr_i;
  assign slow_wdata_o   = data_want[3] ? data_wdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= '0;
      owner_q     <= '0;
      instr_out_q <= 1'b0;
      data_out_q  <= 1'b0;
      instr_unm_q <= 1'b0;
      data_unm_q  <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_SLAVES; i++) begin
        if (s_req[i] && s_gnt[i]) begin
          pend_q[i]  <= 1'b1;
          owner_q[i] <= data_want[i];
        end else if (s_rvalid[i]) begin
          pend_q[i] <= 1'b0;
        end
      end
      if (instr_gnt_o)
        instr_out_q <= 1'b1;
      else if (instr_rvalid_o)
        instr_out_q <= 1'b0;
      if (data_gnt_o)
        data_out_q <= 1'b1;
      else if (data_rvalid_o)
        data_out_q <= 1'b0;
      // unmapped responder answers the next cycle
      instr_unm_q <= instr_unm;
      data_unm_q  <= data_unm;
    end
  end

  a_instr_rvalid_open: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_rvalid_o |-> instr_out_q);
  a_data_rvalid_open: assert property (@(posedge clk_i) disable iff (rst_i)
    data_rvalid_o |-> data_out_q);

endmodule

`default_nettype wire

/* rtl/periph_regs.sv */
// peripheral registers for program exit, a scratch word and a cycle timer
// single-cycle OBI slave that reads unused offsets as zero

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module periph_regs (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_i,
  input  logic           we_i,
  input  mcu_pkg::be_t   be_i,
  input  logic [11:0]    addr_i,
  input  mcu_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output mcu_pkg::data_t rdata_o,
  output logic           exit_valid_o,
  output mcu_pkg::data_t exit_value_o
);

  import mcu_pkg::*;

  data_t       scratch_q;
  data_t       timer_q;
  logic [11:0] word_off;
  logic        wr_en;

  assign gnt_o    = req_i;
  assign word_off = {addr_i[11:2], 2'b00};
  // writes always take the whole word
  assign wr_en    = req_i && we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o     <= 1'b0;
      exit_valid_o <= 1'b0;
      timer_q      <= '0;
    end else begin
      rvalid_o <= req_i;
      timer_q  <= timer_q + 1'b1;
      if (wr_en && word_off == `MCU_PERIPH_EXIT)
        exit_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (word_off)
        `MCU_PERIPH_EXIT:    exit_value_o <= wdata_i;
        `MCU_PERIPH_SCRATCH: scratch_q <= wdata_i;
        default:             ;
      endcase
    end
    if (req_i && !we_i) begin
      case (word_off)
        `MCU_PERIPH_EXIT:    rdata_o <= exit_value_o;
        `MCU_PERIPH_SCRATCH: rdata_o <= scratch_q;
        `MCU_PERIPH_TIMER:   rdata_o <= timer_q;
        default:             rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/slow_memory.sv */
// word RAM with a pseudo-random response delay of 1 to MCU_SLOW_MAX_LAT cycles
// one request at a time with gnt low until the response has gone out

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module slow_memory #(
  parameter int  NUM_WORDS = `MCU_SLOW_WORDS,
  localparam int AW        = $clog2(NUM_WORDS)
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_i,
  input  logic           we_i,
  input  mcu_pkg::be_t   be_i,
  input  logic [AW-1:0]  addr_i,
  input  mcu_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output mcu_pkg::data_t rdata_o
);

  import mcu_pkg::*;

  localparam int CW = $clog2(`MCU_SLOW_MAX_LAT);

  data_t         mem [NUM_WORDS];
  logic          busy_q;
  logic [CW-1:0] cnt_q;
  logic [7:0]    lfsr_q;
  logic          lfsr_fb;
  logic          we_q;
  be_t           be_q;
  logic [AW-1:0] addr_q;
  data_t         wdata_q;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  assign gnt_o    = req_i && !busy_q;
  assign rvalid_o = busy_q && (cnt_q == '0);
  assign rdata_o  = mem[addr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      lfsr_q <= 8'ha5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      if (gnt_o) begin
        busy_q <= 1'b1;
        cnt_q  <= CW'(lfsr_q % `MCU_SLOW_MAX_LAT);
      end else if (rvalid_o) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // request held here and the write lands as the response leaves
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      we_q    <= we_i;
      be_q    <= be_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (rvalid_o && we_q) begin
      for (int b = 0; b < 4; b++) begin
        if (be_q[b])
          mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
      end
    end
  end

  // a new grant only once the previous response has gone out
  a_no_gnt_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt_o |-> !$past(busy_q) || $past(rvalid_o));

endmodule

`default_nettype wire

/* rtl/sram_bank.sv */
// single-cycle word RAM bank on an OBI slave port
// gnt follows req, read data and rvalid one cycle later

`timescale 1ns/1ps
`default_nettype none
`include "mcu_defines.svh"

module sram_bank #(
  parameter int  NUM_WORDS = `MCU_RAM_BYTES / 4,
  localparam int AW        = $clog2(NUM_WORDS)
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_i,
  input  logic           we_i,
  input  mcu_pkg::be_t   be_i,
  input  logic [AW-1:0]  addr_i,
  input  mcu_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output mcu_pkg::data_t rdata_o
);

  import mcu_pkg::*;

  data_t mem [NUM_WORDS];

  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      rvalid_o <= 1'b0;
    else
      rvalid_o <= req_i;
  end

  // read returns the old word on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b])
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

  a_index_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> 32'(addr_i) < NUM_WORDS);

endmodule

`default_nettype wire

/* rtl/mcu_pkg.sv */
// bus types shared by the interconnect, the slaves and the top level
// modules import this inside their bodies

`default_nettype none

package mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // target of a decoded address; slave index matches the value
  typedef enum logic [2:0] {
    SEL_RAM0   = 3'd0,
    SEL_RAM1   = 3'd1,
    SEL_PERIPH = 3'd2,
    SEL_SLOW   = 3'd3,
    SEL_NONE   = 3'd4
  } slave_sel_e;

endpackage

`default_nettype wire

/* rtl/mcu_defines.svh */
// address map, memory sizes and timing bounds of the fabric
// include wherever a base, a size or a register offset is needed

`ifndef MCU_DEFINES_SVH
`define MCU_DEFINES_SVH

// single-cycle RAM banks
`define MCU_RAM0_BASE       32'h0000_0000
`define MCU_RAM1_BASE       32'h0000_4000
`define MCU_RAM_BYTES       32'h0000_4000

// peripheral block, 4 KiB window
`define MCU_PERIPH_BASE     32'h2000_0000
`define MCU_PERIPH_EXIT     12'h000
`define MCU_PERIPH_SCRATCH  12'h004
`define MCU_PERIPH_TIMER    12'h008

// slow RAM with variable latency
`define MCU_SLOW_BASE       32'h3000_0000
`define MCU_SLOW_WORDS      128
`define MCU_SLOW_MAX_LAT    4

`define MCU_UNMAPPED_RDATA  32'hdead_beef

`endif
